//--- hw/core_macros.svh
// Core-wide sizing and reset constants
// Word width, architectural register count and first fetch address

`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data path and instruction width
`define CORE_XLEN 32

// Architectural registers, x0 included
`define CORE_NUM_REGS 32

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

//--- hw/core_pkg.sv
// Shared core types: word, address, register index and retire count
// ALU operation encoding, RV32I major opcodes and the legal-opcode check

`default_nettype none

`include "core_macros.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [`CORE_XLEN-1:0] pc_t;
    typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_addr_t;
    typedef logic [`CORE_XLEN-1:0] retire_count_t;

    // pass_b carries the U-type immediate for LUI
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_t;

    // Major opcodes of the supported groups
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // Anything else retires as an illegal no-op
    function automatic logic is_legal_opcode(input logic [6:0] opcode);
        return (opcode == OPC_OP) || (opcode == OPC_OP_IMM) || (opcode == OPC_LUI);
    endfunction

endpackage

`default_nettype wire

//--- hw/core_if.sv
// issue_if carries the issue packet from decode to the ALU plus the ALU forward pair
// writeback_if carries the registered ALU result to the register file, decode and trace

`default_nettype none

interface issue_if;
    import core_pkg::*;

    logic      valid;
    alu_op_t   op;
    word_t     operand_a;
    word_t     operand_b;
    reg_addr_t rd;
    pc_t       pc;
    word_t     instr;

    // Unregistered result of the instruction in execute
    logic      fwd_valid;
    reg_addr_t fwd_rd;
    word_t     fwd_data;

    modport issuer (
        output valid, op, operand_a, operand_b, rd, pc, instr,
        input  fwd_valid, fwd_rd, fwd_data
    );
    modport unit (
        input  valid, op, operand_a, operand_b, rd, pc, instr,
        output fwd_valid, fwd_rd, fwd_data
    );
endinterface

interface writeback_if;
    import core_pkg::*;

    logic      valid;
    reg_addr_t rd;
    word_t     data;
    pc_t       pc;
    word_t     instr;

    modport source (output valid, rd, data, pc, instr);
    modport sink (input valid, rd, data, pc, instr);
endinterface

`default_nettype wire

//--- hw/fetch.sv
// Fetch unit: program counter, run gate and instruction memory request
// Delays the request by one cycle to line up with the returning data

`default_nettype none

`include "core_macros.svh"

module fetch (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          run,
    output logic          instr_req,
    output core_pkg::pc_t instr_addr,
    output logic          fetch_valid,
    output core_pkg::pc_t fetch_pc
);
    import core_pkg::*;

    pc_t  pc;
    logic running;

    // Set on the first edge after reset release
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    assign instr_req  = run && running;
    assign instr_addr = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc          <= `CORE_RESET_PC;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= instr_req;
            if (instr_req) begin
                pc <= pc + pc_t'(4);
            end
        end
    end

    // Address of the word the memory returns next cycle
    always_ff @(posedge clk) begin
        if (instr_req) begin
            fetch_pc <= pc;
        end
    end

endmodule

`default_nettype wire

//--- hw/decode_and_issue.sv
// Decode and issue stage: opcode decode into ALU operations,
// I-type and U-type immediates, operand forwarding and the issue register

`default_nettype none

module decode_and_issue (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                fetch_valid,
    input  core_pkg::pc_t       fetch_pc,
    input  core_pkg::word_t     instr_data,
    output core_pkg::reg_addr_t rs1_addr,
    output core_pkg::reg_addr_t rs2_addr,
    input  core_pkg::word_t     rs1_data,
    input  core_pkg::word_t     rs2_data,
    issue_if.issuer             issue,
    writeback_if.sink           wb
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt_bit;
    logic       legal;
    word_t      imm_i;
    word_t      imm_u;
    word_t      src_a;
    word_t      src_b;
    word_t      operand_b;
    alu_op_t    op;
    reg_addr_t  rd;

    // Youngest producer wins; x0 is never forwarded
    function automatic word_t select_operand(
        input reg_addr_t addr,
        input word_t     rf_value,
        input logic      fwd_valid,
        input reg_addr_t fwd_rd,
        input word_t     fwd_data,
        input logic      wb_valid,
        input reg_addr_t wb_rd,
        input word_t     wb_data
    );
        if (addr == '0) begin
            return rf_value;
        end
        if (fwd_valid && fwd_rd == addr) begin
            return fwd_data;
        end
        if (wb_valid && wb_rd == addr) begin
            return wb_data;
        end
        return rf_value;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Field extraction
    assign opcode   = instr_data[6:0];
    assign funct3   = instr_data[14:12];
    assign alt_bit  = instr_data[30];
    assign legal    = is_legal_opcode(opcode);
    assign rs1_addr = instr_data[19:15];
    assign rs2_addr = instr_data[24:20];

    // Illegal instructions write nothing
    assign rd = legal ? instr_data[11:7] : '0;

    assign imm_i = {{20{instr_data[31]}}, instr_data[31:20]};
    assign imm_u = {instr_data[31:12], 12'b0};

    ////////////////////////////////////////////////////////////////////////////
    // Operation select
    always_comb begin
        case (funct3)
            3'b000: op = (opcode == OPC_OP && alt_bit) ? alu_sub : alu_add;
            3'b001: op = alu_sll;
            3'b010: op = alu_slt;
            3'b011: op = alu_sltu;
            3'b100: op = alu_xor;
            3'b101: op = alt_bit ? alu_sra : alu_srl;
            3'b110: op = alu_or;
            default: op = alu_and;
        endcase
        if (opcode == OPC_LUI) begin
            op = alu_pass_b;
        end
    end

    assign src_a = select_operand(rs1_addr, rs1_data, issue.fwd_valid, issue.fwd_rd,
                                  issue.fwd_data, wb.valid, wb.rd, wb.data);
    assign src_b = select_operand(rs2_addr, rs2_data, issue.fwd_valid, issue.fwd_rd,
                                  issue.fwd_data, wb.valid, wb.rd, wb.data);

    // Second operand is a register only for OP
    always_comb begin
        case (opcode)
            OPC_OP:  operand_b = src_b;
            OPC_LUI: operand_b = imm_u;
            default: operand_b = imm_i;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Issue register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            issue.op        <= op;
            issue.operand_a <= src_a;
            issue.operand_b <= operand_b;
            issue.rd        <= rd;
            issue.pc        <= fetch_pc;
            issue.instr     <= instr_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/register_file.sv
// Architectural register file with two combinational read ports
// x0 reads as zero, writes from the writeback bus pass straight through

`default_nettype none

`include "core_macros.svh"

module register_file (
    input  logic                clk,
    input  logic                arst_n,
    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,
    writeback_if.sink           wb
);
    import core_pkg::*;

    // Entry 0 is never written
    word_t regs [`CORE_NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Same-cycle write returns the new value
    assign rs1_data = (rs1_addr == '0) ? '0
                    : (wb.valid && wb.rd == rs1_addr) ? wb.data
                    : regs[rs1_addr];

    assign rs2_data = (rs2_addr == '0) ? '0
                    : (wb.valid && wb.rd == rs2_addr) ? wb.data
                    : regs[rs2_addr];

endmodule

`default_nettype wire

//--- hw/alu_unit.sv
// Integer ALU: eleven operations, forward pair back to issue
// and the writeback register

`default_nettype none

module alu_unit (
    input  logic        clk,
    input  logic        arst_n,
    issue_if.unit       issue,
    writeback_if.source wb
);
    import core_pkg::*;

    word_t      result;
    logic [4:0] shamt;

    assign shamt = issue.operand_b[4:0];

    always_comb begin
        case (issue.op)
            alu_add:    result = issue.operand_a + issue.operand_b;
            alu_sub:    result = issue.operand_a - issue.operand_b;
            alu_sll:    result = issue.operand_a << shamt;
            alu_slt:    result = word_t'($signed(issue.operand_a) < $signed(issue.operand_b));
            alu_sltu:   result = word_t'(issue.operand_a < issue.operand_b);
            alu_xor:    result = issue.operand_a ^ issue.operand_b;
            alu_srl:    result = issue.operand_a >> shamt;
            alu_sra:    result = $signed(issue.operand_a) >>> shamt;
            alu_or:     result = issue.operand_a | issue.operand_b;
            alu_and:    result = issue.operand_a & issue.operand_b;
            alu_pass_b: result = issue.operand_b;
            default:    result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Forward pair, one instruction ahead of decode
    assign issue.fwd_valid = issue.valid;
    assign issue.fwd_rd    = issue.rd;
    assign issue.fwd_data  = result;

    ////////////////////////////////////////////////////////////////////////////
    // Writeback register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            wb.rd    <= issue.rd;
            wb.data  <= result;
            wb.pc    <= issue.pc;
            wb.instr <= issue.instr;
        end
    end

endmodule

`default_nettype wire

//--- hw/core_top.sv
// Core top level: fetch, decode and issue, register file and ALU
// joined by the issue and writeback buses
// Registered trace port with a running retire count

`default_nettype none

module core_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    run,

    // Instruction memory, one-cycle read latency
    output logic                    instr_req,
    output core_pkg::pc_t           instr_addr,
    input  core_pkg::word_t         instr_data,

    // Retirement trace
    output logic                    tr_valid,
    output core_pkg::pc_t           tr_pc,
    output core_pkg::word_t         tr_instr,
    output core_pkg::reg_addr_t     tr_rd,
    output core_pkg::word_t         tr_rd_data,
    output logic                    tr_illegal,
    output core_pkg::retire_count_t tr_retired
);
    import core_pkg::*;

    logic      fetch_valid;
    pc_t       fetch_pc;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    issue_if     issue_bus ();
    writeback_if wb_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline
    fetch i_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .instr_req   (instr_req),
        .instr_addr  (instr_addr),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc)
    );

    decode_and_issue i_decode_and_issue (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .instr_data  (instr_data),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .issue       (issue_bus.issuer),
        .wb          (wb_bus.sink)
    );

    register_file i_register_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb_bus.sink)
    );

    alu_unit i_alu_unit (
        .clk    (clk),
        .arst_n (arst_n),
        .issue  (issue_bus.unit),
        .wb     (wb_bus.source)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Trace port, one edge behind writeback
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tr_valid   <= 1'b0;
            tr_retired <= '0;
        end else begin
            tr_valid <= wb_bus.valid;
            if (wb_bus.valid) begin
                tr_retired <= tr_retired + retire_count_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_bus.valid) begin
            tr_pc      <= wb_bus.pc;
            tr_instr   <= wb_bus.instr;
            tr_rd      <= wb_bus.rd;
            tr_rd_data <= wb_bus.data;
            // Flag comes straight from the opcode field
            tr_illegal <= !is_legal_opcode(wb_bus.instr[6:0]);
        end
    end

endmodule

`default_nettype wire

//--- tests/core_tb.sv
// Testbench for core_top with clock, reset and instruction ROM model
// Random program generation, reference model and trace checks

`default_nettype none

`include "core_macros.svh"

module core_tb;
    import core_pkg::*;

    localparam int ROM_WORDS  = 1024;
    localparam int WAIT_LIMIT = 50;

    logic          clk;
    logic          arst_n;
    logic          run;
    logic          instr_req;
    pc_t           instr_addr;
    word_t         instr_data;
    logic          tr_valid;
    pc_t           tr_pc;
    word_t         tr_instr;
    reg_addr_t     tr_rd;
    word_t         tr_rd_data;
    logic          tr_illegal;
    retire_count_t tr_retired;

    word_t  rom [ROM_WORDS];
    word_t  model_regs [`CORE_NUM_REGS];
    integer seed = 32'h4aa1e649;
    int     cycle = 0;
    int     errors = 0;
    int     checks = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     prog_len = 0;
    int     req_count = 0;
    pc_t    next_req_pc = `CORE_RESET_PC;
    logic   fetch_open = 1'b0;
    logic   data_due = 1'b0;
    pc_t    data_addr;
    int     req_cycle_q [$];
    pc_t    req_pc_q [$];

    core_top i_core_top (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;
    always @(posedge clk) cycle++;

    // Fetch may start from the first edge seen out of reset
    always @(posedge clk) fetch_open = arst_n;

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input retire_count_t got,
                               input retire_count_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("timeout: %s", reason);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model of RV32I OP, OP-IMM and LUI on the model registers
    function automatic logic opcode_kept(input word_t instr);
        return instr[6:0] == OPC_OP || instr[6:0] == OPC_OP_IMM || instr[6:0] == OPC_LUI;
    endfunction

    function automatic word_t ref_result(input word_t instr);
        word_t      a;
        word_t      b;
        logic [4:0] sh;
        a  = model_regs[instr[19:15]];
        b  = (instr[6:0] == OPC_OP) ? model_regs[instr[24:20]]
                                    : {{20{instr[31]}}, instr[31:20]};
        sh = b[4:0];
        if (instr[6:0] == OPC_LUI) begin
            return {instr[31:12], 12'h000};
        end
        case (instr[14:12])
            3'd0: return (instr[6:0] == OPC_OP && instr[30]) ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return word_t'($signed(a) < $signed(b));
            3'd3: return word_t'(a < b);
            3'd4: return a ^ b;
            3'd5: return instr[30] ? word_t'($signed(a) >>> sh) : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // One retirement against the oldest outstanding request
    task automatic check_retire();
        int        req_cyc;
        pc_t       pc;
        word_t     instr;
        word_t     exp_data;
        reg_addr_t exp_rd;
        logic      legal;
        if (req_pc_q.size() == 0) begin
            errors++;
            $display("trace retired an instruction at %0t with no request pending", $time);
            return;
        end
        req_cyc = req_cycle_q.pop_front();
        pc      = req_pc_q.pop_front();
        instr   = rom[pc[11:2]];
        legal   = opcode_kept(instr);
        exp_rd  = legal ? instr[11:7] : '0;
        checks++;
        if (cycle - req_cyc != 4) begin
            errors++;
            $display("trace for pc %h came %0d cycles after its request instead of 4",
                     pc, cycle - req_cyc);
        end
        check_word("tr_pc", tr_pc, pc);
        check_word("tr_instr", tr_instr, instr);
        check_word("tr_illegal", word_t'(tr_illegal), word_t'(!legal));
        check_reg("tr_rd", tr_rd, exp_rd);
        if (legal) begin
            exp_data = ref_result(instr);
            check_word("tr_rd_data", tr_rd_data, exp_data);
            if (exp_rd != '0) begin
                model_regs[exp_rd] = exp_data;
            end
        end
    endtask

    // Requests and retirements are sampled mid-cycle
    always @(negedge clk) begin
        check_word("instr_req", word_t'(instr_req), word_t'(run && fetch_open));
        if (instr_req) begin
            check_word("instr_addr", instr_addr, next_req_pc);
            req_cycle_q.push_back(cycle);
            req_pc_q.push_back(next_req_pc);
            next_req_pc = next_req_pc + 32'd4;
            req_count++;
        end
        data_due  = instr_req;
        data_addr = instr_addr;
        if (tr_valid) begin
            check_retire();
        end
    end

    // ROM answers one cycle after the request
    always @(posedge clk) begin
        #1;
        instr_data = data_due ? rom[data_addr[11:2]] : '0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Program generation
    function automatic reg_addr_t small_reg(input int span);
        return reg_addr_t'($unsigned($random(seed)) % span);
    endfunction

    function automatic word_t random_alu(input int span);
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        f3  = 3'($random(seed));
        alt = 1'($random(seed));
        imm = 12'($random(seed));
        rd  = small_reg(span);
        rs1 = small_reg(span);
        rs2 = small_reg(span);
        if (($random(seed) & 1) != 0) begin
            return {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd, OPC_OP};
        end
        // Immediate shifts carry only shamt and the arithmetic bit
        if (f3 == 3'd1 || f3 == 3'd5) begin
            imm = {1'b0, alt && f3 == 3'd5, 5'b0, imm[4:0]};
        end
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic word_t random_illegal();
        word_t w;
        w = $random(seed);
        case (2'($random(seed)))
            2'd0: w[6:0] = 7'b0000011;
            2'd1: w[6:0] = 7'b0100011;
            2'd2: w[6:0] = 7'b1100011;
            default: w[6:0] = 7'b0000000;
        endcase
        w[11:7] = small_reg(6);
        return w;
    endfunction

    task automatic emit(input word_t w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    // Fetches every emitted word, then waits for the trace to catch up
    task automatic run_program(input bit gated);
        int n;
        int start;
        int waited;
        n      = prog_len - req_count;
        start  = req_count;
        waited = 0;
        while (req_count - start < n) begin
            if (waited > 4 * n + 20) begin
                abort_run("fetch did not issue the expected number of requests");
            end
            run = gated ? (($random(seed) & 3) != 0) : 1'b1;
            @(posedge clk);
            #1;
            waited++;
        end
        run    = 1'b0;
        waited = 0;
        while (req_pc_q.size() != 0) begin
            if (waited > WAIT_LIMIT) begin
                abort_run("trace did not retire every requested instruction");
            end
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %-10s ok", name);
        end else begin
            tests_failed++;
            $display("test %-10s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    initial begin
        int        mark;
        reg_addr_t dep;
        word_t     w;
        arst_n     = 1'b0;
        run        = 1'b1;
        instr_data = '0;
        for (int i = 0; i < `CORE_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = word_t'(i) << 7;
        end

        mark = errors;
        repeat (5) begin
            @(negedge clk);
            check_word("instr_req", word_t'(instr_req), '0);
            check_word("tr_valid", word_t'(tr_valid), '0);
            check_count("tr_retired", tr_retired, '0);
        end
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        for (int i = 0; i < 8; i++) begin
            emit(random_alu(8));
        end
        run_program(1'b0);
        finish_test("reset", mark);

        mark = errors;
        for (int i = 0; i < 60; i++) begin
            emit(random_alu(8));
        end
        run_program(1'b0);
        finish_test("alu", mark);

        // Chains where each result is read d instructions later
        mark = errors;
        for (int d = 1; d <= 3; d++) begin
            for (int i = 0; i < 12; i++) begin
                dep     = reg_addr_t'(1 + i % d);
                w       = random_alu(6);
                w[11:7] = dep;
                w[19:15] = dep;
                emit(w);
            end
        end
        run_program(1'b0);
        finish_test("hazards", mark);

        mark = errors;
        for (int i = 0; i < 10; i++) begin
            emit({20'($random(seed)), small_reg(4), OPC_LUI});
            emit({12'($random(seed)), small_reg(4), 3'b000, 5'd0, OPC_OP_IMM});
            emit({7'b0, small_reg(4), 5'd0, 3'b000, 5'd5, OPC_OP});
        end
        run_program(1'b0);
        finish_test("x0_lui", mark);

        mark = errors;
        for (int i = 0; i < 40; i++) begin
            emit((i % 3 == 0) ? random_illegal() : random_alu(6));
        end
        run_program(1'b0);
        finish_test("illegal", mark);

        mark = errors;
        for (int i = 0; i < 60; i++) begin
            emit((i % 7 == 3) ? random_illegal() : random_alu(6));
        end
        run_program(1'b1);
        check_count("tr_retired", tr_retired, retire_count_t'(req_count));
        finish_test("run_gate", mark);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+hw
hw/core_pkg.sv
hw/core_if.sv
hw/fetch.sv
hw/decode_and_issue.sv
hw/register_file.sv
hw/alu_unit.sv
hw/core_top.sv
tests/core_tb.sv

//--- Makefile
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Status comes from the search for the pass line in the output
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)
